/* logic/matrix_pkg.sv */
/*
 * Shared widths, types and byte encodings of the matrix calculator.
 * Modules import it inside their bodies and use scoped names on ports.
 */
package matrix_pkg;

    parameter int ELEM_W = 8;
    parameter int DIM_W = 4;
    parameter int SLOT_W = 3;
    // Index of an element inside one slot region
    parameter int IDX_W = 2 * DIM_W;
    parameter int SLOT_NUM = 2 ** SLOT_W;

    typedef logic [ELEM_W-1:0] elem_t;
    typedef logic [DIM_W-1:0] dim_t;
    typedef logic [SLOT_W-1:0] slot_t;

    // Encoded as the mode select value that enters each mode
    typedef enum logic [2:0] {
        MODE_MENU    = 3'd0,
        MODE_INPUT   = 3'd1,
        MODE_DISPLAY = 3'd3,
        MODE_COMPUTE = 3'd4
    } mode_e;

    typedef enum logic [3:0] {
        ERR_NONE  = 4'd0,
        ERR_DIM   = 4'd1,
        ERR_SLOT  = 4'd2,
        ERR_OP    = 4'd3,
        ERR_SHAPE = 4'd4,
        ERR_FULL  = 4'd5
    } err_e;

    typedef enum logic [1:0] {
        OP_ADD       = 2'd0,
        OP_TRANSPOSE = 2'd1,
        OP_SCALE     = 2'd2,
        OP_RESERVED  = 2'd3
    } op_e;

    typedef struct packed {
        dim_t rows;
        dim_t cols;
    } dim_hdr_t;

    typedef struct packed {
        op_e   op;
        slot_t slot_a;
        slot_t slot_b;
    } op_cmd_t;

    // Header in input mode, command in display and compute modes
    typedef union packed {
        dim_hdr_t dims;
        op_cmd_t  cmd;
    } cmd_byte_u;

    // Execute request kind for a slot display or an operation
    typedef struct packed {
        logic show;
        op_e  op;
    } kind_t;

endpackage

/* logic/matrix_if.sv */
/*
 * Buses between the decoder, the slot storage, the execute stage
 * and the output FIFO. Each bus has one modport per side.
 */
`timescale 1ns/1ps

// ==================================================
// Storage bus
// ==================================================
interface store_if;
    import matrix_pkg::*;

    // Element writes and slot commit from the decoder
    logic wr_en;
    slot_t wr_slot;
    logic [IDX_W-1:0] wr_index;
    elem_t wr_data;
    logic commit;
    slot_t commit_slot;
    dim_hdr_t commit_dims;

    // Reads from the execute stage with data one cycle later
    logic rd_en;
    slot_t rd_slot;
    logic [IDX_W-1:0] rd_index;
    elem_t rd_data;

    // Slot table
    logic [SLOT_NUM-1:0] slot_valid;
    dim_hdr_t slot_dims [SLOT_NUM];

    modport writer (
        output wr_en, wr_slot, wr_index, wr_data, commit, commit_slot, commit_dims,
        input  slot_valid
    );
    modport reader (
        output rd_en, rd_slot, rd_index,
        input  rd_data, slot_dims
    );
    modport memory (
        input  wr_en, wr_slot, wr_index, wr_data, commit, commit_slot, commit_dims,
        input  rd_en, rd_slot, rd_index,
        output rd_data, slot_valid, slot_dims
    );
endinterface

// ==================================================
// Execute request bus
// ==================================================
interface exec_if;
    import matrix_pkg::*;

    logic start;
    kind_t kind;
    slot_t slot_a;
    slot_t slot_b;
    logic busy;
    logic shape_err;

    modport requester (output start, kind, slot_a, slot_b, input busy, shape_err);
    modport engine (input start, kind, slot_a, slot_b, output busy, shape_err);
endinterface

// Result byte stream
interface result_if;
    import matrix_pkg::*;

    logic push;
    elem_t data;
    logic full;

    modport producer (output push, data, input full);
    modport consumer (input push, data, output full);
endinterface

/* logic/mode_decode.sv */
/*
 * Mode FSM and byte parser. Input mode writes elements and commits
 * slots; display and compute modes check commands and start the
 * execute stage. Holds the error code shown at the top level.
 */
`timescale 1ns/1ps

module mode_decode #(
    parameter int MAX_DIM = 4,
    parameter int SLOT_COUNT = 8
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic [2:0]          mode_sel,
    input  logic                confirm,
    input  logic                back,
    input  matrix_pkg::elem_t   rx_data,
    input  logic                rx_valid,
    output matrix_pkg::mode_e   mode,
    output matrix_pkg::err_e    error_code,
    store_if.writer             st,
    exec_if.requester           ex
);
    import matrix_pkg::*;

    mode_e mode_next;
    logic mode_change;
    cmd_byte_u rx_u;
    logic dim_bad;
    logic free_found;
    slot_t free_slot;
    logic in_body;
    logic [IDX_W-1:0] elem_cnt;
    logic [IDX_W-1:0] elem_total;
    dim_hdr_t hdr_q;
    slot_t fill_slot;
    logic show;
    kind_t cmd_kind;
    slot_t cmd_a;
    err_e cmd_err;

    assign rx_u = rx_data;

    // ==================================================
    // Mode FSM
    // ==================================================
    always_comb begin
        mode_next = mode;
        if (mode == MODE_MENU) begin
            if (confirm) begin
                case (mode_sel)
                    3'd1, 3'd3, 3'd4: mode_next = mode_e'(mode_sel);
                    default: mode_next = MODE_MENU;
                endcase
            end
        end else if (back) begin
            mode_next = MODE_MENU;
        end
    end

    assign mode_change = (mode_next != mode);

    // ==================================================
    // Byte checks
    // ==================================================
    assign dim_bad = (rx_u.dims.rows == '0) || (rx_u.dims.cols == '0) ||
                     (rx_u.dims.rows > MAX_DIM) || (rx_u.dims.cols > MAX_DIM);

    // Lowest free slot wins
    always_comb begin
        free_found = 1'b0;
        free_slot = '0;
        for (int i = SLOT_COUNT - 1; i >= 0; i--) begin
            if (!st.slot_valid[i]) begin
                free_found = 1'b1;
                free_slot = slot_t'(i);
            end
        end
    end

    assign elem_total = IDX_W'(hdr_q.rows) * IDX_W'(hdr_q.cols);

    // A display byte keeps its slot in the low bits, where the B field sits
    always_comb begin
        show = (mode == MODE_DISPLAY);
        cmd_kind.show = show;
        cmd_kind.op = rx_u.cmd.op;
        cmd_a = show ? rx_u.cmd.slot_b : rx_u.cmd.slot_a;
        cmd_err = ERR_NONE;
        if (!show && rx_u.cmd.op == OP_RESERVED) begin
            cmd_err = ERR_OP;
        end else if (!st.slot_valid[cmd_a]) begin
            cmd_err = ERR_SLOT;
        end else if (!show && rx_u.cmd.op == OP_ADD && !st.slot_valid[rx_u.cmd.slot_b]) begin
            cmd_err = ERR_SLOT;
        end
    end

    // ==================================================
    // Control and error register
    // ==================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mode <= MODE_MENU;
            error_code <= ERR_NONE;
            in_body <= 1'b0;
            elem_cnt <= '0;
            st.wr_en <= 1'b0;
            st.commit <= 1'b0;
            ex.start <= 1'b0;
        end else begin
            mode <= mode_next;
            st.wr_en <= 1'b0;
            st.commit <= 1'b0;
            ex.start <= 1'b0;
            if (mode_change) begin
                error_code <= ERR_NONE;
                in_body <= 1'b0;
            end else if (ex.shape_err) begin
                error_code <= ERR_SHAPE;
            end else if (rx_valid && mode == MODE_INPUT) begin
                error_code <= ERR_NONE;
                if (!in_body) begin
                    if (dim_bad) begin
                        error_code <= ERR_DIM;
                    end else if (!free_found) begin
                        error_code <= ERR_FULL;
                    end else begin
                        in_body <= 1'b1;
                        elem_cnt <= '0;
                    end
                end else begin
                    st.wr_en <= 1'b1;
                    elem_cnt <= elem_cnt + 1'b1;
                    if (elem_cnt == elem_total - 1'b1) begin
                        in_body <= 1'b0;
                        st.commit <= 1'b1;
                    end
                end
            end else if (rx_valid && mode != MODE_MENU && !ex.busy && !ex.start) begin
                error_code <= cmd_err;
                ex.start <= (cmd_err == ERR_NONE);
            end
        end
    end

    // Payload registers
    always_ff @(posedge clk) begin
        if (rx_valid && !in_body) begin
            hdr_q <= rx_u.dims;
            fill_slot <= free_slot;
        end
        if (rx_valid) begin
            st.wr_slot <= fill_slot;
            st.wr_index <= elem_cnt;
            st.wr_data <= rx_data;
            ex.kind <= cmd_kind;
            ex.slot_a <= cmd_a;
            ex.slot_b <= rx_u.cmd.slot_b;
        end
    end

    assign st.commit_slot = fill_slot;
    assign st.commit_dims = hdr_q;

endmodule

/* logic/matrix_store.sv */
/*
 * Slot table and element memory. Each slot owns a fixed region of
 * MAX_DIM x MAX_DIM elements; one write port, one registered read port.
 */
`timescale 1ns/1ps

module matrix_store #(
    parameter int MAX_DIM = 4,
    parameter int SLOT_COUNT = 8
) (
    input logic clk,
    input logic rst_n,
    store_if.memory st
);
    import matrix_pkg::*;

    localparam int REGION = MAX_DIM * MAX_DIM;
    localparam int DEPTH = SLOT_COUNT * REGION;
    localparam int AW = $clog2(DEPTH);

    elem_t mem [DEPTH];
    logic [SLOT_NUM-1:0] valid_q;
    dim_hdr_t dims_q [SLOT_NUM];
    logic [AW-1:0] wr_addr;
    logic [AW-1:0] rd_addr;

    // Slot base plus element index
    assign wr_addr = AW'(st.wr_slot) * AW'(REGION) + AW'(st.wr_index);
    assign rd_addr = AW'(st.rd_slot) * AW'(REGION) + AW'(st.rd_index);

    // Slots fill up over time and only reset empties them
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else if (st.commit) begin
            valid_q[st.commit_slot] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (st.commit) begin
            dims_q[st.commit_slot] <= st.commit_dims;
        end
        if (st.wr_en) begin
            mem[wr_addr] <= st.wr_data;
        end
        // Read data holds until the next read
        if (st.rd_en) begin
            st.rd_data <= mem[rd_addr];
        end
    end

    assign st.slot_valid = valid_q;
    assign st.slot_dims = dims_q;

endmodule

/* logic/matrix_exec.sv */
/*
 * Execute stage. Sends the result header, then walks the result
 * row-major, reading operands from storage and pushing one byte per
 * element. ADD reads A then B through the single read port.
 */
`timescale 1ns/1ps

module matrix_exec (
    input logic clk,
    input logic rst_n,
    store_if.reader st,
    exec_if.engine ex,
    result_if.producer rs
);
    import matrix_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,
        S_HDR,
        S_RUN
    } state_e;

    state_e state;
    kind_t kind_q;
    slot_t slot_a_q;
    slot_t slot_b_q;
    dim_hdr_t dims_a;
    dim_hdr_t dims_b;
    dim_hdr_t res_dims;
    logic is_add;
    logic is_tr;
    logic is_scale;
    logic shape_bad;
    dim_t row;
    dim_t col;
    logic ph;
    logic reads_done;
    logic pend;
    logic pend_b;
    elem_t a_q;
    elem_t elem_val;
    logic push_el;
    logic take_a;
    logic issue;

    assign is_add = !kind_q.show && (kind_q.op == OP_ADD);
    assign is_tr = !kind_q.show && (kind_q.op == OP_TRANSPOSE);
    assign is_scale = !kind_q.show && (kind_q.op == OP_SCALE);

    assign dims_a = st.slot_dims[slot_a_q];
    assign dims_b = st.slot_dims[slot_b_q];
    assign res_dims = is_tr ? {dims_a.cols, dims_a.rows} : dims_a;
    assign shape_bad = is_add && (dims_a != dims_b);

    // ==================================================
    // Read and push pipeline
    // ==================================================
    // Pend marks an operand in rd_data that is used before the next read
    assign push_el = (state == S_RUN) && pend && (!is_add || pend_b) && !rs.full;
    assign take_a = (state == S_RUN) && pend && is_add && !pend_b;
    assign issue = (state == S_RUN) && !reads_done && (!pend || push_el || take_a);

    assign st.rd_en = issue;
    assign st.rd_slot = ph ? slot_b_q : slot_a_q;
    // Transpose reads A at (col, row) of the result position
    assign st.rd_index = is_tr ? IDX_W'(col) * IDX_W'(dims_a.cols) + IDX_W'(row)
                               : IDX_W'(row) * IDX_W'(dims_a.cols) + IDX_W'(col);

    always_comb begin
        if (is_add) begin
            elem_val = a_q + st.rd_data;
        end else if (is_scale) begin
            elem_val = st.rd_data * elem_t'(slot_b_q);
        end else begin
            elem_val = st.rd_data;
        end
    end

    assign rs.push = ((state == S_HDR) && !shape_bad && !rs.full) || push_el;
    assign rs.data = (state == S_HDR) ? elem_t'(res_dims) : elem_val;

    assign ex.busy = (state != S_IDLE);
    assign ex.shape_err = (state == S_HDR) && shape_bad;

    // ==================================================
    // Sequencing
    // ==================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= S_IDLE;
            row <= '0;
            col <= '0;
            ph <= 1'b0;
            reads_done <= 1'b0;
            pend <= 1'b0;
            pend_b <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (ex.start) begin
                        state <= S_HDR;
                    end
                end
                S_HDR: begin
                    if (shape_bad) begin
                        state <= S_IDLE;
                    end else if (!rs.full) begin
                        state <= S_RUN;
                        row <= '0;
                        col <= '0;
                        ph <= 1'b0;
                        reads_done <= 1'b0;
                    end
                end
                default: begin
                    // Last element pushed
                    if (push_el && reads_done) begin
                        state <= S_IDLE;
                    end
                end
            endcase

            if (issue) begin
                pend <= 1'b1;
                pend_b <= ph;
                if (is_add && !ph) begin
                    ph <= 1'b1;
                end else begin
                    ph <= 1'b0;
                    if (col == res_dims.cols - 1'b1) begin
                        col <= '0;
                        if (row == res_dims.rows - 1'b1) begin
                            reads_done <= 1'b1;
                        end else begin
                            row <= row + 1'b1;
                        end
                    end else begin
                        col <= col + 1'b1;
                    end
                end
            end else if (push_el || take_a) begin
                pend <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_IDLE && ex.start) begin
            kind_q <= ex.kind;
            slot_a_q <= ex.slot_a;
            slot_b_q <= ex.slot_b;
        end
        if (take_a) begin
            a_q <= st.rd_data;
        end
    end

endmodule

/* logic/result_tx.sv */
/*
 * Four-byte output FIFO. The head byte goes out with tx_start on
 * every cycle that the transmitter is not busy.
 */
`timescale 1ns/1ps

module result_tx (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              tx_busy,
    output matrix_pkg::elem_t tx_data,
    output logic              tx_start,
    result_if.consumer        rs
);
    import matrix_pkg::*;

    localparam int DEPTH = 4;
    localparam int PW = $clog2(DEPTH);

    elem_t fifo [DEPTH];
    // One extra wrap bit on each pointer tells full from empty
    logic [PW:0] wp;
    logic [PW:0] rp;
    logic empty;

    assign empty = (wp == rp);
    assign rs.full = (wp[PW] != rp[PW]) && (wp[PW-1:0] == rp[PW-1:0]);

    assign tx_start = !empty && !tx_busy;
    assign tx_data = fifo[rp[PW-1:0]];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wp <= '0;
            rp <= '0;
        end else begin
            if (rs.push) begin
                wp <= wp + 1'b1;
            end
            if (tx_start) begin
                rp <= rp + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rs.push) begin
            fifo[wp[PW-1:0]] <= rs.data;
        end
    end

endmodule

/* logic/matrix_calc_top.sv */
/*
 * Matrix calculator top level. Bytes arrive on rx_data/rx_valid and
 * leave on tx_data/tx_start; the mode comes from mode_sel and the
 * confirm and back pulses.
 */
`timescale 1ns/1ps

module matrix_calc_top #(
    parameter int MAX_DIM = 4,
    parameter int SLOT_COUNT = 8
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic [2:0]        mode_sel,
    input  logic              confirm,
    input  logic              back,
    input  matrix_pkg::elem_t rx_data,
    input  logic              rx_valid,
    input  logic              tx_busy,
    output matrix_pkg::elem_t tx_data,
    output logic              tx_start,
    output matrix_pkg::mode_e mode,
    output matrix_pkg::err_e  error_code
);

    store_if st_bus ();
    exec_if ex_bus ();
    result_if rs_bus ();

    // ==================================================
    // Decode, storage, execute, output
    // ==================================================
    mode_decode #(
        .MAX_DIM    (MAX_DIM),
        .SLOT_COUNT (SLOT_COUNT)
    ) i_mode_decode (
        .clk        (clk),
        .rst_n      (rst_n),
        .mode_sel   (mode_sel),
        .confirm    (confirm),
        .back       (back),
        .rx_data    (rx_data),
        .rx_valid   (rx_valid),
        .mode       (mode),
        .error_code (error_code),
        .st         (st_bus.writer),
        .ex         (ex_bus.requester)
    );

    matrix_store #(
        .MAX_DIM    (MAX_DIM),
        .SLOT_COUNT (SLOT_COUNT)
    ) i_matrix_store (
        .clk   (clk),
        .rst_n (rst_n),
        .st    (st_bus.memory)
    );

    matrix_exec i_matrix_exec (
        .clk   (clk),
        .rst_n (rst_n),
        .st    (st_bus.reader),
        .ex    (ex_bus.engine),
        .rs    (rs_bus.producer)
    );

    result_tx i_result_tx (
        .clk      (clk),
        .rst_n    (rst_n),
        .tx_busy  (tx_busy),
        .tx_data  (tx_data),
        .tx_start (tx_start),
        .rs       (rs_bus.consumer)
    );

endmodule

/* sim/matrix_calc_properties.sv */
/*
 * Concurrent checks on the calculator's top level ports. Bound into
 * matrix_calc_top by the bind statement below the module.
 */
`timescale 1ns/1ps

module matrix_calc_properties (
    input logic              clk,
    input logic              rst_n,
    input logic              confirm,
    input logic              tx_busy,
    input logic              tx_start,
    input matrix_pkg::mode_e mode,
    input matrix_pkg::err_e  error_code
);
    import matrix_pkg::*;

    // Transmitter never started while busy
    no_start_when_busy: assert property (
        @(posedge clk) disable iff (!rst_n) tx_busy |-> !tx_start
    ) else $error("tx_start high while tx_busy is high");

    error_code_legal: assert property (
        @(posedge clk) disable iff (!rst_n)
        error_code inside {ERR_NONE, ERR_DIM, ERR_SLOT, ERR_OP, ERR_SHAPE, ERR_FULL}
    ) else $error("error_code holds an undefined value 0x%01h", error_code);

    // Leaving the menu takes a confirm on the cycle before
    menu_exit_on_confirm: assert property (
        @(posedge clk) disable iff (!rst_n)
        (mode != MODE_MENU && $past(mode) == MODE_MENU) |-> $past(confirm)
    ) else $error("mode left the menu without confirm");

endmodule

bind matrix_calc_top matrix_calc_properties i_matrix_calc_properties (
    .clk        (clk),
    .rst_n      (rst_n),
    .confirm    (confirm),
    .tx_busy    (tx_busy),
    .tx_start   (tx_start),
    .mode       (mode),
    .error_code (error_code)
);

/* sim/tb_matrix_calc.sv */
/*
 * Testbench for the matrix calculator. Replays the steps of the golden
 * file through the byte interface and checks output bytes, error code
 * and mode after each step. tx_busy is raised on random cycles.
 */
`timescale 1ns/1ps

module tb_matrix_calc;
    import matrix_pkg::*;

    localparam int GOLD_DEPTH = 512;
    localparam int SETTLE_CYCLES = 16;
    localparam int CYCLES_PER_BYTE = 64;
    localparam int MARGIN_CYCLES = 1000;

    logic clk;
    logic rst_n;
    logic [2:0] mode_sel;
    logic confirm;
    logic back;
    elem_t rx_data;
    logic rx_valid;
    logic tx_busy;
    elem_t tx_data;
    logic tx_start;
    mode_e mode;
    err_e error_code;

    logic [7:0] gold [GOLD_DEPTH];
    elem_t out_q [$];
    integer seed;
    int errors;
    int limit_cycles;

    matrix_calc_top i_matrix_calc_top (
        .clk        (clk),
        .rst_n      (rst_n),
        .mode_sel   (mode_sel),
        .confirm    (confirm),
        .back       (back),
        .rx_data    (rx_data),
        .rx_valid   (rx_valid),
        .tx_busy    (tx_busy),
        .tx_data    (tx_data),
        .tx_start   (tx_start),
        .mode       (mode),
        .error_code (error_code)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Transmitter busy on about one cycle in four
    initial begin
        seed = 32'he4eb_a661;
        tx_busy = 1'b0;
        forever begin
            @(negedge clk);
            tx_busy = (($random(seed) & 32'd3) == 32'd0);
        end
    end

    // Every byte handed to the transmitter in order
    always @(posedge clk) begin
        if (rst_n && tx_start) begin
            out_q.push_back(tx_data);
        end
    end

    // Watchdog armed once the golden file is counted
    initial begin
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge clk);
        $display("Timeout: the steps did not finish within %0d cycles", limit_cycles);
        $display("Regression failed");
        $finish;
    end

    // ==================================================
    // Checks
    // ==================================================
    task automatic check_byte(input int step, input int idx, input elem_t got, input elem_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED tx_data byte %0d of step %0d: got 0x%02h, expected 0x%02h",
                     idx, step, got, exp);
            errors++;
        end
    endtask

    task automatic check_err(input int step, input err_e got, input err_e exp);
        if (got !== exp) begin
            $display("CHECK FAILED error_code in step %0d: got 0x%01h, expected 0x%01h",
                     step, got, exp);
            errors++;
        end
    endtask

    task automatic check_mode(input int step, input mode_e got, input mode_e exp);
        if (got !== exp) begin
            $display("CHECK FAILED mode in step %0d: got 0x%01h, expected 0x%01h",
                     step, got, exp);
            errors++;
        end
    endtask

    // Only select values 1, 3 and 4 leave the menu
    function automatic mode_e expected_mode(input logic [2:0] sel);
        case (sel)
            3'd1: return MODE_INPUT;
            3'd3: return MODE_DISPLAY;
            3'd4: return MODE_COMPUTE;
            default: return MODE_MENU;
        endcase
    endfunction

    // ==================================================
    // Stimulus
    // ==================================================
    task automatic change_mode(input logic [2:0] sel);
        if (mode != MODE_MENU) begin
            @(negedge clk);
            back = 1'b1;
            @(negedge clk);
            back = 1'b0;
        end
        @(negedge clk);
        mode_sel = sel;
        confirm = 1'b1;
        @(negedge clk);
        confirm = 1'b0;
    endtask

    // Idle cycles after each byte let a slot commit reach the table
    task automatic send_byte(input elem_t value);
        @(negedge clk);
        rx_data = value;
        rx_valid = 1'b1;
        @(negedge clk);
        rx_valid = 1'b0;
        @(negedge clk);
    endtask

    task automatic await_output(input int count, input int limit, output logic arrived);
        int waited;
        waited = 0;
        while (out_q.size() < count && waited < limit) begin
            @(negedge clk);
            waited++;
        end
        arrived = (out_q.size() >= count);
    endtask

    initial begin
        int pos;
        int step;
        int i;
        int n_in;
        int n_out;
        int total;
        int errors_before;
        int bad_steps;
        logic [7:0] sel;
        logic arrived;

        rst_n = 1'b0;
        mode_sel = 3'd0;
        confirm = 1'b0;
        back = 1'b0;
        rx_data = '0;
        rx_valid = 1'b0;
        errors = 0;
        limit_cycles = 0;
        bad_steps = 0;
        step = 0;

        $readmemh("sim/calc_golden.txt", gold);

        // Byte count of all steps sets the run length
        total = 0;
        pos = 0;
        while (pos < GOLD_DEPTH && gold[pos] !== 8'hff) begin
            n_in = int'(gold[pos + 1]);
            n_out = int'(gold[pos + 2 + n_in]);
            total += n_in + n_out;
            pos += n_in + n_out + 4;
        end
        limit_cycles = total * CYCLES_PER_BYTE + MARGIN_CYCLES;

        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_mode(0, mode, MODE_MENU);
        check_err(0, error_code, ERR_NONE);

        if (pos >= GOLD_DEPTH) begin
            $display("The golden file has no end marker, no steps were run");
            errors++;
        end else begin
            pos = 0;
            while (gold[pos] !== 8'hff) begin
                step++;
                errors_before = errors;
                sel = gold[pos];
                n_in = int'(gold[pos + 1]);
                n_out = int'(gold[pos + 2 + n_in]);
                if (step == 1 || sel[2:0] != mode_sel ||
                    expected_mode(sel[2:0]) == MODE_MENU) begin
                    change_mode(sel[2:0]);
                    check_mode(step, mode, expected_mode(sel[2:0]));
                end
                out_q.delete();
                for (i = 0; i < n_in; i++) begin
                    send_byte(gold[pos + 2 + i]);
                end

                await_output(n_out, (n_in + n_out) * CYCLES_PER_BYTE + SETTLE_CYCLES, arrived);
                if (!arrived) begin
                    $display("Step %0d: only %0d of %0d output bytes arrived",
                             step, out_q.size(), n_out);
                    errors++;
                end
                for (i = 0; i < n_out && i < out_q.size(); i++) begin
                    check_byte(step, i, out_q[i], gold[pos + 3 + n_in + i]);
                end

                // Quiet window for late errors and stray bytes
                repeat (SETTLE_CYCLES) @(negedge clk);
                if (out_q.size() > n_out) begin
                    $display("Step %0d: %0d output bytes more than expected",
                             step, out_q.size() - n_out);
                    errors++;
                end
                check_err(step, error_code, err_e'(gold[pos + 3 + n_in + n_out][3:0]));

                if (errors == errors_before) begin
                    $display("Step %0d, mode_sel %0d: ok", step, sel[2:0]);
                end else begin
                    $display("Step %0d, mode_sel %0d: %0d errors", step, sel[2:0],
                             errors - errors_before);
                    bad_steps++;
                end
                pos += n_in + n_out + 4;
            end
        end

        $display("Steps run: %0d, steps with errors: %0d, errors: %0d", step, bad_steps, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

/* sim/calc_golden.txt */
// Step: mode_sel, input count, input bytes, output count, output bytes, error code
// A mode_sel of ff ends the list
01 07 23 01 55 90 7f ab fe 00 00
03 01 00 07 23 01 55 90 7f ab fe 00
04 01 40 07 32 01 7f 55 ab 90 fe 00
04 01 83 07 23 03 ff b0 7d 01 fa 00
01 07 23 10 20 30 f0 60 02 00 00
04 01 01 07 23 11 75 c0 6f 0b 00 00
// Dimension errors, then a 3x2 matrix into slot 2
01 01 03 00 01
01 01 53 00 01
01 07 32 01 02 03 04 05 06 00 00
// Empty slot, reserved operation, unequal shapes
03 01 05 00 02
04 01 c0 00 03
04 01 02 00 04
// Slots 3 to 7 with 1x1 matrices, then storage full
01 0a 11 a3 11 a4 11 a5 11 a6 11 a7 00 00
01 01 11 00 05
03 01 07 02 11 a7 00
// Select value 2 keeps the menu
02 00 00 00
ff

/* compile.f */
logic/matrix_pkg.sv
logic/matrix_if.sv
logic/mode_decode.sv
logic/matrix_store.sv
logic/matrix_exec.sv
logic/result_tx.sv
logic/matrix_calc_top.sv
sim/matrix_calc_properties.sv
sim/tb_matrix_calc.sv

/* Makefile */
# Verilator build and run of the matrix calculator testbench

sim:
	verilator --binary --timing --assert -Wno-fatal -f compile.f \
		--top-module tb_matrix_calc -Mdir obj_dir
	./obj_dir/Vtb_matrix_calc > sim.log 2>&1 || true
	cat sim.log
	@! grep -q "Regression failed" sim.log
	@grep -q "Regression passed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
